/* eth_rx_cfg.svh */
// Receive FIFO configuration
`ifndef ETH_RX_CFG_SVH
`define ETH_RX_CFG_SVH

// Beat payload width
`define ETH_DATA_WIDTH 64

// One byte enable per data byte
`define ETH_KEEP_WIDTH 8

// PTP time in 96-bit format
`define PTP_TS_WIDTH 96

// FIFO capacity in beats, power of two
`define RX_FIFO_DEPTH 32

// log2 of the depth
`define RX_FIFO_ADDR_WIDTH 5

`endif

/* eth_rx_pkg.sv */
// Receive FIFO types
`default_nettype none

`include "eth_rx_cfg.svh"

package eth_rx_pkg;

    // Beat payload
    typedef logic [`ETH_DATA_WIDTH-1:0] eth_data_t;

    // Byte enables
    typedef logic [`ETH_KEEP_WIDTH-1:0] eth_keep_t;

    // PTP timestamp
    typedef logic [`PTP_TS_WIDTH-1:0] ptp_ts_t;

    // FIFO address
    typedef logic [`RX_FIFO_ADDR_WIDTH-1:0] fifo_addr_t;

    // Occupancy, one extra bit to hold a full count
    typedef logic [`RX_FIFO_ADDR_WIDTH:0] fifo_count_t;

    // One stream beat with its frame timestamp
    typedef struct packed {
        eth_data_t data;
        eth_keep_t keep;
        logic      last;
        // Only meaningful on the last beat
        logic      bad;
        ptp_ts_t   ts;
    } rx_beat_t;

endpackage

`default_nettype wire

/* eth_rx_ts_fifo.sv */
// Timestamped receive FIFO top
`default_nettype none

`include "eth_rx_cfg.svh"

module eth_rx_ts_fifo
    import eth_rx_pkg::*;
(
    input  wire logic      logic_clk,
    input  wire logic      logic_rst,
    input  wire eth_data_t in_data,
    input  wire eth_keep_t in_keep,
    input  wire logic      in_valid,
    input  wire logic      in_last,
    input  wire logic      in_bad,
    input  wire ptp_ts_t   ptp_ts_96,
    output wire eth_data_t out_data,
    output wire eth_keep_t out_keep,
    output wire logic      out_last,
    output wire logic      out_valid,
    input  wire logic      out_ready,
    output wire ptp_ts_t   ts_out,
    output wire logic      ts_valid,
    input  wire logic      ts_ready,
    output wire logic      overflow,
    output wire logic      bad_frame,
    output wire logic      good_frame
);

    // Tagged beats into the FIFO
    rx_beat_t tag_beat;
    logic     tag_valid;

    // Committed beats toward the extractor
    rx_beat_t fifo_beat;
    logic     fifo_valid;
    logic     fifo_ready;

    rx_ts_tagger tagger0 (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .in_data    (in_data),
        .in_keep    (in_keep),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .in_bad     (in_bad),
        .ptp_ts_96  (ptp_ts_96),
        .tag_beat   (tag_beat),
        .tag_valid  (tag_valid)
    );

    rx_frame_fifo fifo0 (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .tag_beat   (tag_beat),
        .tag_valid  (tag_valid),
        .fifo_beat  (fifo_beat),
        .fifo_valid (fifo_valid),
        .fifo_ready (fifo_ready),
        .overflow   (overflow),
        .bad_frame  (bad_frame),
        .good_frame (good_frame)
    );

    rx_ts_extract extract0 (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .fifo_beat  (fifo_beat),
        .fifo_valid (fifo_valid),
        .fifo_ready (fifo_ready),
        .out_data   (out_data),
        .out_keep   (out_keep),
        .out_last   (out_last),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .ts_out     (ts_out),
        .ts_valid   (ts_valid),
        .ts_ready   (ts_ready)
    );

endmodule

`default_nettype wire

/* rx_frame_fifo.sv */
// Frame-mode receive FIFO
`default_nettype none

`include "eth_rx_cfg.svh"

module rx_frame_fifo
    import eth_rx_pkg::*;
(
    input  wire logic     logic_clk,
    input  wire logic     logic_rst,
    input  wire rx_beat_t tag_beat,
    input  wire logic     tag_valid,
    output rx_beat_t      fifo_beat,
    output logic          fifo_valid,
    input  wire logic     fifo_ready,
    output logic          overflow,
    output logic          bad_frame,
    output logic          good_frame
);

    localparam fifo_count_t DEPTH = fifo_count_t'(`RX_FIFO_DEPTH);

    rx_beat_t    mem [`RX_FIFO_DEPTH];

    // Committed, speculative and read pointers
    fifo_addr_t  wr_ptr;
    fifo_addr_t  wr_ptr_spec;
    fifo_addr_t  rd_ptr;
    logic        drop_frame;

    // Beats from read pointer to each write pointer
    fifo_count_t spec_count;
    fifo_count_t commit_count;
    fifo_count_t spec_count_next;
    fifo_count_t commit_count_next;

    logic        full;
    logic        wr_en;
    logic        rd_en;
    logic        frame_end;
    logic        do_commit;
    logic        do_overflow;
    logic        do_bad;

    assign full  = (spec_count == DEPTH);
    assign wr_en = tag_valid && !drop_frame && !full;

    // Decision at the last beat, overflow wins over a bad flag
    assign frame_end   = tag_valid && tag_beat.last;
    assign do_overflow = frame_end && (drop_frame || full);
    assign do_bad      = frame_end && !do_overflow && tag_beat.bad;
    assign do_commit   = frame_end && !do_overflow && !tag_beat.bad;

    // Pop only committed beats into a free output register
    assign rd_en = (commit_count != '0) && (!fifo_valid || fifo_ready);

    always_comb begin
        spec_count_next   = spec_count + fifo_count_t'(wr_en) - fifo_count_t'(rd_en);
        commit_count_next = commit_count - fifo_count_t'(rd_en);
        if (do_commit) begin
            commit_count_next = spec_count_next;
        end else if (do_overflow || do_bad) begin
            // Rollback forgets the partial frame
            spec_count_next = commit_count_next;
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr       <= '0;
            wr_ptr_spec  <= '0;
            rd_ptr       <= '0;
            spec_count   <= '0;
            commit_count <= '0;
            drop_frame   <= 1'b0;
        end else begin
            spec_count   <= spec_count_next;
            commit_count <= commit_count_next;

            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (do_commit) begin
                wr_ptr      <= wr_ptr_spec + 1'b1;
                wr_ptr_spec <= wr_ptr_spec + 1'b1;
            end else if (do_overflow || do_bad) begin
                wr_ptr_spec <= wr_ptr;
            end else if (wr_en) begin
                wr_ptr_spec <= wr_ptr_spec + 1'b1;
            end

            // Out of room mid-frame, ignore the rest of it
            if (frame_end) begin
                drop_frame <= 1'b0;
            end else if (tag_valid && full) begin
                drop_frame <= 1'b1;
            end
        end
    end

    // One-cycle status pulses
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            overflow   <= 1'b0;
            bad_frame  <= 1'b0;
            good_frame <= 1'b0;
        end else begin
            overflow   <= do_overflow;
            bad_frame  <= do_bad;
            good_frame <= do_commit;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr_spec] <= tag_beat;
        end
    end

    // Read side output register
    always_ff @(posedge logic_clk) begin
        if (rd_en) begin
            fifo_beat <= mem[rd_ptr];
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            fifo_valid <= 1'b0;
        end else if (rd_en) begin
            fifo_valid <= 1'b1;
        end else if (fifo_ready) begin
            fifo_valid <= 1'b0;
        end
    end

    status_onehot_a: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        $onehot0({overflow, bad_frame, good_frame})
    );

    // Reader stays behind the committed pointer
    rd_behind_commit_a: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        (commit_count <= spec_count) &&
        (fifo_addr_t'(wr_ptr - rd_ptr) == commit_count[`RX_FIFO_ADDR_WIDTH-1:0])
    );

endmodule

`default_nettype wire

/* rx_ts_extract.sv */
// Receive timestamp extractor
`default_nettype none

`include "eth_rx_cfg.svh"

module rx_ts_extract
    import eth_rx_pkg::*;
(
    input  wire logic      logic_clk,
    input  wire logic      logic_rst,
    input  wire rx_beat_t  fifo_beat,
    input  wire logic      fifo_valid,
    output logic           fifo_ready,
    output eth_data_t      out_data,
    output eth_keep_t      out_keep,
    output logic           out_last,
    output logic           out_valid,
    input  wire logic      out_ready,
    output ptp_ts_t        ts_out,
    output logic           ts_valid,
    input  wire logic      ts_ready
);

    // Next accepted beat opens a frame
    logic first_beat;
    logic stream_free;
    logic ts_free;
    logic take;

    assign stream_free = !out_valid || out_ready;
    assign ts_free     = !ts_valid || ts_ready;

    // A first beat waits until the previous stamp is gone
    assign fifo_ready = stream_free && (!first_beat || ts_free);
    assign take       = fifo_valid && fifo_ready;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            first_beat <= 1'b1;
            out_valid  <= 1'b0;
            ts_valid   <= 1'b0;
        end else begin
            if (take) begin
                first_beat <= fifo_beat.last;
            end

            if (take) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end

            if (take && first_beat) begin
                ts_valid <= 1'b1;
            end else if (ts_ready) begin
                ts_valid <= 1'b0;
            end
        end
    end

    // Stream output register
    always_ff @(posedge logic_clk) begin
        if (take) begin
            out_data <= fifo_beat.data;
            out_keep <= fifo_beat.keep;
            out_last <= fifo_beat.last;
        end
    end

    // Timestamp register
    always_ff @(posedge logic_clk) begin
        if (take && first_beat) begin
            ts_out <= fifo_beat.ts;
        end
    end

    out_stable_a: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    );

    // Bad frames are discarded upstream
    no_bad_beat_a: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        fifo_valid |-> !fifo_beat.bad
    );

endmodule

`default_nettype wire

/* rx_ts_tagger.sv */
// Receive timestamp tagger
`default_nettype none

`include "eth_rx_cfg.svh"

module rx_ts_tagger
    import eth_rx_pkg::*;
(
    input  wire logic      logic_clk,
    input  wire logic      logic_rst,
    input  wire eth_data_t in_data,
    input  wire eth_keep_t in_keep,
    input  wire logic      in_valid,
    input  wire logic      in_last,
    input  wire logic      in_bad,
    input  wire ptp_ts_t   ptp_ts_96,
    output rx_beat_t       tag_beat,
    output logic           tag_valid
);

    // High between the first and the last beat of a frame
    logic    in_frame;
    ptp_ts_t held_ts;
    ptp_ts_t frame_ts;

    // First beat takes the live time, later beats the held copy
    assign frame_ts = in_frame ? held_ts : ptp_ts_96;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            in_frame  <= 1'b0;
            tag_valid <= 1'b0;
        end else begin
            tag_valid <= in_valid;
            if (in_valid) begin
                in_frame <= !in_last;
            end
        end
    end

    // Stamp latched at frame start
    always_ff @(posedge logic_clk) begin
        if (in_valid && !in_frame) begin
            held_ts <= ptp_ts_96;
        end
    end

    // Output beat register
    always_ff @(posedge logic_clk) begin
        if (in_valid) begin
            tag_beat.data <= in_data;
            tag_beat.keep <= in_keep;
            tag_beat.last <= in_last;
            tag_beat.bad  <= in_bad;
            tag_beat.ts   <= frame_ts;
        end
    end

    // MAC flags errors on the closing beat only
    bad_on_last_a: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        (in_valid && in_bad) |-> in_last
    );

    // Every beat of a frame carries the stamp of its first beat
    ts_held_a: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        (tag_valid && !tag_beat.last && in_valid) |=> $stable(tag_beat.ts)
    );

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
eth_rx_pkg.sv
rx_ts_tagger.sv
rx_frame_fifo.sv
rx_ts_extract.sv
eth_rx_ts_fifo.sv
tb_eth_rx_ts_fifo.sv

/* tb_eth_rx_ts_fifo.sv */
// Receive FIFO testbench
`default_nettype none

`include "eth_rx_cfg.svh"

module tb_eth_rx_ts_fifo
    import eth_rx_pkg::*;
;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_FRAMES = 7;

    // One row per frame: length, keep on last beat, bad flag, output stall
    typedef struct packed {
        logic [7:0] len;
        eth_keep_t  last_keep;
        logic       bad;
        logic       stall;
    } frame_row_t;

    frame_row_t frame_table [NUM_FRAMES] = '{
        '{8'd3,  8'hff, 1'b0, 1'b0},
        '{8'd1,  8'h01, 1'b0, 1'b0},
        '{8'd4,  8'h0f, 1'b1, 1'b0},
        // Longer than the FIFO
        '{8'd40, 8'hff, 1'b0, 1'b0},
        '{8'd5,  8'h3f, 1'b0, 1'b1},
        '{8'd2,  8'h07, 1'b0, 1'b1},
        '{8'd6,  8'h7f, 1'b0, 1'b0}
    };

    logic      logic_clk;
    logic      logic_rst;
    eth_data_t in_data;
    eth_keep_t in_keep;
    logic      in_valid;
    logic      in_last;
    logic      in_bad;
    ptp_ts_t   ptp_ts_96;
    eth_data_t out_data;
    eth_keep_t out_keep;
    logic      out_last;
    logic      out_valid;
    logic      out_ready;
    ptp_ts_t   ts_out;
    logic      ts_valid;
    logic      ts_ready;
    logic      overflow;
    logic      bad_frame;
    logic      good_frame;

    logic [15:0] lfsr_state;

    // Expected output, in delivery order
    eth_data_t exp_data [$];
    eth_keep_t exp_keep [$];
    logic      exp_last [$];
    ptp_ts_t   exp_ts [$];

    int unsigned good_count;
    int unsigned bad_count;
    int unsigned ovf_count;
    int unsigned exp_good;
    int unsigned exp_bad;
    int unsigned exp_ovf;

    eth_rx_ts_fifo dut0 (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .in_data    (in_data),
        .in_keep    (in_keep),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .in_bad     (in_bad),
        .ptp_ts_96  (ptp_ts_96),
        .out_data   (out_data),
        .out_keep   (out_keep),
        .out_last   (out_last),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .ts_out     (ts_out),
        .ts_valid   (ts_valid),
        .ts_ready   (ts_ready),
        .overflow   (overflow),
        .bad_frame  (bad_frame),
        .good_frame (good_frame)
    );

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic next_random_word(output eth_data_t w);
        for (int i = 0; i < `ETH_DATA_WIDTH; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[i] = lfsr_state[0];
        end
    endtask

    task automatic stop_failed();
        $display("Test FAILED");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic report_mismatch(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_failed();
    endtask

    initial begin
        logic_clk = 1'b0;
        forever #(CLK_PERIOD / 2) logic_clk = ~logic_clk;
    end

    // Free-running PTP time
    always @(posedge logic_clk) begin
        ptp_ts_96 <= ptp_ts_96 + 1;
    end

    always @(posedge logic_clk) begin
        if (!logic_rst) begin
            if (good_frame) good_count++;
            if (bad_frame) bad_count++;
            if (overflow) ovf_count++;
        end
    end

    always @(posedge logic_clk) begin : stream_check
        eth_data_t d;
        eth_keep_t k;
        logic      l;
        if (!logic_rst && out_valid && out_ready) begin
            assert (exp_data.size() != 0)
            else report_mismatch("unexpected beat on out_data");
            d = exp_data.pop_front();
            k = exp_keep.pop_front();
            l = exp_last.pop_front();
            assert (out_data == d)
            else report_mismatch($sformatf("out_data %h, expected %h", out_data, d));
            assert (out_keep == k)
            else report_mismatch($sformatf("out_keep %h, expected %h", out_keep, k));
            assert (out_last == l)
            else report_mismatch($sformatf("out_last %b, expected %b", out_last, l));
        end
    end

    always @(posedge logic_clk) begin : ts_check
        ptp_ts_t t;
        if (!logic_rst && ts_valid && ts_ready) begin
            assert (exp_ts.size() != 0)
            else report_mismatch("unexpected timestamp on ts_out");
            t = exp_ts.pop_front();
            assert (ts_out == t)
            else report_mismatch($sformatf("ts_out %h, expected %h", ts_out, t));
        end
    end

    initial begin : watchdog
        int unsigned total_beats;
        total_beats = 0;
        foreach (frame_table[i]) begin
            total_beats += frame_table[i].len;
        end
        #((total_beats + 200) * CLK_PERIOD);
        $display("Watchdog expired with frames or timestamps still undelivered");
        stop_failed();
    end

    initial begin : stimulus
        eth_data_t  word;
        ptp_ts_t    first_ts;
        frame_row_t row;
        logic       keep_frame;
        logic_rst  = 1'b1;
        in_data    = '0;
        in_keep    = '0;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        in_bad     = 1'b0;
        ptp_ts_96  = '0;
        out_ready  = 1'b1;
        ts_ready   = 1'b1;
        lfsr_state = 16'd91;
        good_count = 0;
        bad_count  = 0;
        ovf_count  = 0;
        exp_good   = 0;
        exp_bad    = 0;
        exp_ovf    = 0;
        repeat (16) @(posedge logic_clk);
        assert (!out_valid && !ts_valid && !overflow && !bad_frame && !good_frame)
        else report_mismatch("outputs not idle during reset");
        logic_rst <= 1'b0;
        repeat (4) @(posedge logic_clk);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            row = frame_table[f];
            keep_frame = !row.bad && (row.len <= `RX_FIFO_DEPTH);
            if (keep_frame) exp_good++;
            else if (row.bad) exp_bad++;
            else exp_ovf++;
            for (int b = 0; b < row.len; b++) begin
                @(posedge logic_clk);
                next_random_word(word);
                if (b == 0) begin
                    // Counter steps on this same edge
                    first_ts = ptp_ts_96 + 1;
                    out_ready <= !row.stall;
                    ts_ready  <= !row.stall;
                    if (keep_frame) exp_ts.push_back(first_ts);
                end
                in_valid <= 1'b1;
                in_data  <= word;
                in_keep  <= (b == row.len - 1) ? row.last_keep : 8'hff;
                in_last  <= (b == row.len - 1);
                in_bad   <= row.bad && (b == row.len - 1);
                if (keep_frame) begin
                    exp_data.push_back(word);
                    exp_keep.push_back((b == row.len - 1) ? row.last_keep : 8'hff);
                    exp_last.push_back(b == row.len - 1);
                end
            end
            @(posedge logic_clk);
            in_valid <= 1'b0;
            in_last  <= 1'b0;
            in_bad   <= 1'b0;
            @(posedge logic_clk);
        end

        out_ready <= 1'b1;
        ts_ready  <= 1'b1;
        while (exp_data.size() != 0 || exp_ts.size() != 0) begin
            @(posedge logic_clk);
        end
        repeat (20) @(posedge logic_clk);

        assert (good_count == exp_good)
        else report_mismatch($sformatf("good_frame pulses %0d, expected %0d",
                                       good_count, exp_good));
        assert (bad_count == exp_bad)
        else report_mismatch($sformatf("bad_frame pulses %0d, expected %0d",
                                       bad_count, exp_bad));
        assert (ovf_count == exp_ovf)
        else report_mismatch($sformatf("overflow pulses %0d, expected %0d",
                                       ovf_count, exp_ovf));
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
